//--- eth_regs_pkg.sv
// Transmit register map only; registers are 8 bits wide on a 16-bit Wishbone bus with byte lanes
`default_nettype none

package eth_regs_pkg;

    // ------------------------------
    // Register map
    // ------------------------------
    // Index is {wb_adr_i, wb_sel_i[1]}
    typedef logic [1:0] reg_idx_t;

    localparam reg_idx_t REG_TX_STAT = 2'd0;    // Status, any write clears the sent flag
    localparam reg_idx_t REG_TX_CNTL = 2'd1;    // Send bit plus buffer address MSBs
    localparam reg_idx_t REG_TX_ADDR = 2'd2;    // Buffer address LSBs
    localparam reg_idx_t REG_TX_DATA = 2'd3;    // Buffer data port

    typedef logic [7:0] bus_byte_t;             // One register or buffer byte

    // ------------------------------
    // Status and control layout
    // ------------------------------
    localparam int CNTL_PAD_W = 4;              // Unused control bits 6..3
    localparam int CNTL_MSB_W = 3;              // Buffer address bits 10..8

    // Transmit status, bit 7 down to bit 0
    typedef struct packed {
        logic       sent;                       // FSENT, frame done and engine idle
        logic       transmitting;               // FTTX, frame still on the line
        logic [5:0] zero;                       // Reads zero
    } tx_status_t;

    // Transmit control, bit 7 down to bit 0
    typedef struct packed {
        logic                  send;            // FTSND, clears itself once busy is seen
        logic [CNTL_PAD_W-1:0] pad;             // Reads zero
        logic [CNTL_MSB_W-1:0] addr_msb;        // Upper buffer address
    } tx_control_t;

endpackage

`default_nettype wire

//--- tenbaset_pkg.sv
// Line constants assume a 20 MHz clock, two clocks per Manchester bit and a 2 KB frame buffer
`default_nettype none

package tenbaset_pkg;

    // ------------------------------
    // Frame buffer
    // ------------------------------
    localparam int BUF_ADDR_W = 11;                 // 2048 bytes
    localparam int BUF_DEPTH  = 2 ** BUF_ADDR_W;

    typedef logic [BUF_ADDR_W-1:0] buf_addr_t;      // Buffer byte address

    // ------------------------------
    // Line timing
    // ------------------------------
    typedef logic [3:0] phase_t;                    // Half-bit slot inside a byte, 16 per byte
    typedef logic [2:0] tail_cnt_t;                 // Idle tail counter

    // TP_IDL: line held high this many clocks after the last bit
    localparam int IDLE_TAIL_CYCLES = 6;

    // Transmit engine states
    // Buffer sequencer only walks IDLE and SEND, the line encoder adds the tail
    typedef enum logic [1:0] {
        TX_IDLE,                                    // Link pulses only
        TX_SEND,                                    // Frame bytes going out
        TX_TAIL                                     // Line high after the frame
    } tx_state_e;

endpackage

`default_nettype wire

//--- eth_tx_regs.sv
// One-cycle strobes only, no wait states; a send bit written while busy clears without a new frame
`timescale 1ns/100ps
`default_nettype none

module eth_tx_regs (
    input  wire                          clk20,
    input  wire                          wb_rst_i,      // Async reset, active high
    input  wire  [15:0]                  wb_dat_i,
    input  wire                          wb_cyc_i,
    input  wire                          wb_stb_i,
    input  wire                          wb_adr_i,
    input  wire  [1:0]                   wb_sel_i,
    input  wire                          wb_we_i,
    input  wire eth_regs_pkg::bus_byte_t rd_byte_i,     // Buffer byte at buf_addr_o
    input  wire                          tx_busy_i,     // Frame on the line
    output logic [15:0]                  wb_dat_o,
    output logic                         wb_ack_o,
    output logic                         buf_wr_o,      // One-cycle buffer write
    output tenbaset_pkg::buf_addr_t      buf_addr_o,
    output eth_regs_pkg::bus_byte_t      buf_wdata_o,
    output logic                         tx_start_o     // One-cycle frame start
);

    // ------------------------------
    // Bus decode
    // ------------------------------
    eth_regs_pkg::reg_idx_t    reg_idx;
    eth_regs_pkg::bus_byte_t   dat_in;          // Selected write lane
    eth_regs_pkg::bus_byte_t   rd_mux;
    eth_regs_pkg::tx_status_t  status;
    eth_regs_pkg::tx_control_t ctrl_q;          // Send bit and address MSBs
    eth_regs_pkg::bus_byte_t   addr_lsb_q;      // Address LSBs
    logic                      bus_req;
    logic                      wr_cmd;
    logic                      rd_cmd;
    logic                      sent_q;          // FSENT
    logic                      send_d;          // Send bit one cycle late

    assign dat_in  = wb_sel_i[0] ? wb_dat_i[7:0] : wb_dat_i[15:8];
    assign reg_idx = {wb_adr_i, wb_sel_i[1]};
    assign bus_req = wb_cyc_i & wb_stb_i;
    assign wr_cmd  = bus_req &  wb_we_i;
    assign rd_cmd  = bus_req & ~wb_we_i;

    assign status     = {sent_q, tx_busy_i, 6'b000000};
    assign buf_addr_o = {ctrl_q.addr_msb, addr_lsb_q};     // Full 11-bit byte address

    always_comb begin
        case (reg_idx)
            eth_regs_pkg::REG_TX_STAT: rd_mux = status;
            eth_regs_pkg::REG_TX_CNTL: rd_mux = ctrl_q;     // Pad bits are always zero
            eth_regs_pkg::REG_TX_ADDR: rd_mux = addr_lsb_q;
            default:                   rd_mux = rd_byte_i;  // Data port
        endcase
    end

    // ------------------------------
    // Acknowledge and read data
    // ------------------------------
    always_ff @(posedge clk20 or posedge wb_rst_i) begin
        if (wb_rst_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= bus_req;                // One edge after the strobe
        end
    end

    always_ff @(posedge clk20) begin
        if (rd_cmd) begin
            // Byte goes back on the lane it was asked for
            wb_dat_o <= wb_sel_i[0] ? {8'h00, rd_mux} : {rd_mux, 8'h00};
        end
        if (wr_cmd && (reg_idx == eth_regs_pkg::REG_TX_DATA)) begin
            buf_wdata_o <= dat_in;
        end
    end

    // ------------------------------
    // Control, flags and strobes
    // ------------------------------
    always_ff @(posedge clk20 or posedge wb_rst_i) begin
        if (wb_rst_i) begin
            ctrl_q     <= '0;
            addr_lsb_q <= '0;
            sent_q     <= 1'b0;                 // Sets on the first clock after reset
            send_d     <= 1'b0;
            tx_start_o <= 1'b0;
            buf_wr_o   <= 1'b0;
        end else begin
            buf_wr_o <= wr_cmd && (reg_idx == eth_regs_pkg::REG_TX_DATA);

            if (wr_cmd) begin
                case (reg_idx)
                    eth_regs_pkg::REG_TX_CNTL: begin
                        ctrl_q.send     <= dat_in[7];
                        ctrl_q.addr_msb <= dat_in[2:0];
                    end
                    eth_regs_pkg::REG_TX_ADDR: addr_lsb_q <= dat_in;
                    default: ;                  // Status clear handled below, data via buf_wr_o
                endcase
            end

            // Engine picked the frame up
            if (ctrl_q.send && tx_busy_i) begin
                ctrl_q.send <= 1'b0;
            end

            // Rising edge of the send bit, never while a frame is still going
            send_d     <= ctrl_q.send;
            tx_start_o <= ctrl_q.send & ~send_d & ~tx_busy_i;

            if ((wr_cmd && (reg_idx == eth_regs_pkg::REG_TX_STAT)) || ctrl_q.send) begin
                sent_q <= 1'b0;
            end else if (!tx_busy_i) begin
                sent_q <= 1'b1;                 // Idle again
            end
        end
    end

    // Buffer takes one byte per strobe, a held write would store the byte twice
    a_buf_wr_single: assert property (@(posedge clk20) disable iff (wb_rst_i)
        buf_wr_o |=> !buf_wr_o)
        else $error("buffer write strobe high on two cycles");

endmodule

`default_nettype wire

//--- eth_tx_buffer.sv
// Frame always starts at address 0 and runs through buf_addr_i; the buffer is not locked while sending
`timescale 1ns/100ps
`default_nettype none

module eth_tx_buffer (
    input  wire                          clk20,
    input  wire                          wb_rst_i,      // Async reset, active high
    input  wire                          buf_wr_i,
    input  wire tenbaset_pkg::buf_addr_t buf_addr_i,    // Bus address, also the last frame byte
    input  wire eth_regs_pkg::bus_byte_t buf_wdata_i,
    input  wire                          tx_start_i,
    input  wire                          next_byte_i,   // Shifter loads tx_byte_o
    output eth_regs_pkg::bus_byte_t      rd_byte_o,
    output logic                         tx_busy_o,
    output eth_regs_pkg::bus_byte_t      tx_byte_o,
    output logic                         tx_sending_o
);

    eth_regs_pkg::bus_byte_t mem [tenbaset_pkg::BUF_DEPTH];
    tenbaset_pkg::tx_state_e state_q;
    tenbaset_pkg::buf_addr_t rd_addr_q;    // Byte offered to the shifter
    logic                    last_q;       // Byte at buf_addr_i already handed over

    // ------------------------------
    // Storage
    // ------------------------------
    assign rd_byte_o = mem[buf_addr_i];     // Async read for the bus

    always_ff @(posedge clk20) begin
        if (buf_wr_i) begin
            mem[buf_addr_i] <= buf_wdata_i;
        end
        tx_byte_o <= mem[rd_addr_q];        // Registered, settles well before the next load
    end

    // ------------------------------
    // Frame sequencer
    // ------------------------------
    always_ff @(posedge clk20 or posedge wb_rst_i) begin
        if (wb_rst_i) begin
            state_q   <= tenbaset_pkg::TX_IDLE;
            rd_addr_q <= '0;
            last_q    <= 1'b0;
        end else begin
            case (state_q)
                tenbaset_pkg::TX_SEND: begin
                    if (next_byte_i) begin
                        // Load after the last byte ends the frame
                        if (last_q) begin
                            state_q <= tenbaset_pkg::TX_IDLE;
                        end
                        last_q    <= (rd_addr_q == buf_addr_i);
                        rd_addr_q <= rd_addr_q + 1'b1;
                    end
                end
                default: begin
                    rd_addr_q <= '0;        // Byte 0 ready before the first load
                    last_q    <= 1'b0;
                    if (tx_start_i) begin
                        state_q <= tenbaset_pkg::TX_SEND;
                    end
                end
            endcase
        end
    end

    assign tx_sending_o = (state_q == tenbaset_pkg::TX_SEND);
    assign tx_busy_o    = tx_sending_o;     // FTTX

    // Register block holds off the start while busy, so a frame is never restarted midway
    a_start_idle: assert property (@(posedge clk20) disable iff (wb_rst_i)
        tx_start_i |-> (state_q != tenbaset_pkg::TX_SEND))
        else $error("frame start while a frame is being sent");

endmodule

`default_nettype wire

//--- tenbaset_txd.sv
// Needs a 20 MHz clock for 10 Mb/s; no preamble is added, the frame bytes go out exactly as buffered
`timescale 1ns/100ps
`default_nettype none

module tenbaset_txd #(
    parameter int LINK_PULSE_W = 18     // Link pulse every 2**LINK_PULSE_W clocks
) (
    input  wire                          clk20,
    input  wire                          wb_rst_i,      // Async reset, active high
    input  wire eth_regs_pkg::bus_byte_t tx_byte_i,     // Next frame byte
    input  wire                          tx_sending_i,
    output logic                         next_byte_o,   // Load pulse, every 16 clocks
    output logic                         Ethernet_tx_o
);

    tenbaset_pkg::phase_t    phase_q;       // Half-bit slot, bit index is phase_q[3:1]
    eth_regs_pkg::bus_byte_t shift_q;       // LSB goes out first
    tenbaset_pkg::tx_state_e state_q;       // Line state
    tenbaset_pkg::tail_cnt_t tail_q;
    logic [LINK_PULSE_W-1:0] lp_cnt_q;
    logic                    link_pulse;
    logic                    manchester;
    logic                    line_d;

    // ------------------------------
    // Byte shifter
    // ------------------------------
    assign next_byte_o = tx_sending_i && (phase_q == '1);

    always_ff @(posedge clk20 or posedge wb_rst_i) begin
        if (wb_rst_i) begin
            phase_q <= '1;
        end else begin
            phase_q <= tx_sending_i ? phase_q + 1'b1 : '1;  // Parked at 15 so the first load is at once
        end
    end

    always_ff @(posedge clk20) begin
        if (next_byte_o) begin
            shift_q <= tx_byte_i;
        end else if (tx_sending_i && phase_q[0]) begin
            shift_q <= {1'b0, shift_q[7:1]};                // After the second half-bit
        end
    end

    // First half inverted, second half true
    assign manchester = ~shift_q[0] ^ phase_q[0];

    // ------------------------------
    // Line state and idle tail
    // ------------------------------
    always_ff @(posedge clk20 or posedge wb_rst_i) begin
        if (wb_rst_i) begin
            state_q <= tenbaset_pkg::TX_IDLE;
            tail_q  <= '0;
        end else begin
            case (state_q)
                tenbaset_pkg::TX_IDLE: begin
                    if (tx_sending_i) state_q <= tenbaset_pkg::TX_SEND;
                end
                tenbaset_pkg::TX_SEND: begin
                    if (!tx_sending_i) begin
                        state_q <= tenbaset_pkg::TX_TAIL;
                        tail_q  <= 3'd1;    // First tail clock is the exit edge
                    end
                end
                default: begin
                    tail_q <= tail_q + 1'b1;
                    if (tx_sending_i) begin
                        state_q <= tenbaset_pkg::TX_SEND;
                    end else if (tail_q == tenbaset_pkg::tail_cnt_t'(
                                     tenbaset_pkg::IDLE_TAIL_CYCLES - 1)) begin
                        state_q <= tenbaset_pkg::TX_IDLE;
                    end
                end
            endcase
        end
    end

    // ------------------------------
    // Link pulses, NLP
    // ------------------------------
    always_ff @(posedge clk20 or posedge wb_rst_i) begin
        if (wb_rst_i) begin
            lp_cnt_q <= '0;
        end else begin
            lp_cnt_q <= tx_sending_i ? '0 : lp_cnt_q + 1'b1;
        end
    end

    assign link_pulse = &lp_cnt_q[LINK_PULSE_W-1:1];        // Top two counts, two clocks wide

    always_comb begin
        case (state_q)
            tenbaset_pkg::TX_SEND: line_d = tx_sending_i ? manchester : 1'b1;
            tenbaset_pkg::TX_TAIL: line_d = 1'b1;           // TP_IDL
            default:               line_d = link_pulse;
        endcase
    end

    always_ff @(posedge clk20 or posedge wb_rst_i) begin
        if (wb_rst_i) begin
            Ethernet_tx_o <= 1'b0;
        end else begin
            Ethernet_tx_o <= line_d;
        end
    end

endmodule

`default_nettype wire

//--- wb_ethernet_tx.sv
// 10BASE-T transmit only, single 20 MHz clock, master must hold each strobe for exactly one cycle
`timescale 1ns/100ps
`default_nettype none

module wb_ethernet_tx #(
    parameter int LINK_PULSE_W = 18     // 18 gives a link pulse about every 13 ms
) (
    input  wire         clk20,          // Bus and line clock
    input  wire         wb_rst_i,       // Async reset, active high
    input  wire  [15:0] wb_dat_i,
    output logic [15:0] wb_dat_o,
    input  wire         wb_cyc_i,
    input  wire         wb_stb_i,
    input  wire         wb_adr_i,
    input  wire  [1:0]  wb_sel_i,       // Bit 0 picks the lane, bit 1 is part of the index
    input  wire         wb_we_i,
    output logic        wb_ack_o,
    output logic        Ethernet_tx_o   // Manchester line to the PHY
);

    // ------------------------------
    // Bus side to buffer
    // ------------------------------
    logic                    buf_wr;
    tenbaset_pkg::buf_addr_t buf_addr;
    eth_regs_pkg::bus_byte_t buf_wdata;
    eth_regs_pkg::bus_byte_t rd_byte;
    logic                    tx_start;
    logic                    tx_busy;

    // ------------------------------
    // Buffer to line encoder
    // ------------------------------
    eth_regs_pkg::bus_byte_t tx_byte;
    logic                    tx_sending;
    logic                    next_byte;

    eth_tx_regs u_regs (
        .clk20       (clk20),
        .wb_rst_i    (wb_rst_i),
        .wb_dat_i    (wb_dat_i),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_adr_i    (wb_adr_i),
        .wb_sel_i    (wb_sel_i),
        .wb_we_i     (wb_we_i),
        .rd_byte_i   (rd_byte),
        .tx_busy_i   (tx_busy),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_o    (wb_ack_o),
        .buf_wr_o    (buf_wr),
        .buf_addr_o  (buf_addr),
        .buf_wdata_o (buf_wdata),
        .tx_start_o  (tx_start)
    );

    eth_tx_buffer u_buffer (
        .clk20        (clk20),
        .wb_rst_i     (wb_rst_i),
        .buf_wr_i     (buf_wr),
        .buf_addr_i   (buf_addr),
        .buf_wdata_i  (buf_wdata),
        .tx_start_i   (tx_start),
        .next_byte_i  (next_byte),
        .rd_byte_o    (rd_byte),
        .tx_busy_o    (tx_busy),
        .tx_byte_o    (tx_byte),
        .tx_sending_o (tx_sending)
    );

    tenbaset_txd #(
        .LINK_PULSE_W (LINK_PULSE_W)
    ) u_txd (
        .clk20         (clk20),
        .wb_rst_i      (wb_rst_i),
        .tx_byte_i     (tx_byte),
        .tx_sending_i  (tx_sending),
        .next_byte_o   (next_byte),
        .Ethernet_tx_o (Ethernet_tx_o)
    );

endmodule

`default_nettype wire

//--- tb_wb_ethernet_tx.sv
// Run from the project root so wb_ethernet_tx_stim.txt is found; LINK_PULSE_W is 8 for short link pulse gaps
`timescale 1ns/100ps
`default_nettype none

module tb_wb_ethernet_tx;

    localparam int LP_W     = 8;                // Link pulse every 256 clocks
    localparam int STIM_LEN = 256;
    localparam int TAIL     = 6;                // Line high clocks after the last bit

    logic        clk20;
    logic        wb_rst_i;
    logic [15:0] wb_dat_i;
    logic [15:0] wb_dat_o;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic        wb_adr_i;
    logic [1:0]  wb_sel_i;
    logic        wb_we_i;
    logic        wb_ack_o;
    logic        Ethernet_tx_o;

    logic [15:0] stim_mem [0:STIM_LEN-1];      // Frame records
    logic [7:0]  frame_q [$];                   // Bytes of the frame under test
    logic [31:0] rng_state;
    int          err_cnt;
    int          test_cnt;
    int          test_fail;
    int          test_err0;                     // Error count when the test began
    int          cycle_cnt   = 0;
    int          cycle_limit = 0;

    wb_ethernet_tx #(
        .LINK_PULSE_W (LP_W)
    ) dut0 (
        .clk20         (clk20),
        .wb_rst_i      (wb_rst_i),
        .wb_dat_i      (wb_dat_i),
        .wb_dat_o      (wb_dat_o),
        .wb_cyc_i      (wb_cyc_i),
        .wb_stb_i      (wb_stb_i),
        .wb_adr_i      (wb_adr_i),
        .wb_sel_i      (wb_sel_i),
        .wb_we_i       (wb_we_i),
        .wb_ack_o      (wb_ack_o),
        .Ethernet_tx_o (Ethernet_tx_o)
    );

    always #50 clk20 = ~clk20;                  // 100 ns period

    // Watchdog, limit is set once the stim file is read
    always @(posedge clk20) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout, run went past %0d clock cycles", cycle_limit);
            $display("sim failed");
            $finish;
        end
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic finish_test(input string name);
        test_cnt++;
        if (err_cnt != test_err0) begin
            test_fail++;
            $display("test %s: FAIL, %0d errors", name, err_cnt - test_err0);
        end else begin
            $display("test %s: ok", name);
        end
        test_err0 = err_cnt;
    endtask

    // One-cycle strobe on the low lane; lag counts falling edges since the strobe was driven
    task automatic bus_access(input logic we, input logic [1:0] idx, input logic [7:0] wdata,
                              output logic [7:0] rdata, output int lag);
        @(negedge clk20);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = idx[1];
        wb_sel_i = {idx[0], 1'b1};              // sel[1] is the low index bit
        wb_dat_i = {8'h00, wdata};
        @(negedge clk20);
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        lag = 1;
        while (!wb_ack_o && lag < 8) begin
            @(negedge clk20);
            lag++;
        end
        if (!wb_ack_o) begin
            $display("No acknowledge from the DUT for register %0d", idx);
            err_cnt++;
        end
        rdata = wb_dat_o[7:0];
    endtask

    // Write strobe and then a read strobe on the very next cycle
    task automatic write_then_read(input logic [1:0] wr_idx, input logic [7:0] wdata,
                                   input logic [1:0] rd_idx, output logic [7:0] rdata);
        @(negedge clk20);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = 1'b1;
        wb_adr_i = wr_idx[1];
        wb_sel_i = {wr_idx[0], 1'b1};
        wb_dat_i = {8'h00, wdata};
        @(negedge clk20);
        wb_we_i  = 1'b0;                        // Second access, a read
        wb_adr_i = rd_idx[1];
        wb_sel_i = {rd_idx[0], 1'b1};
        @(negedge clk20);
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        if (!wb_ack_o) begin
            $display("No acknowledge from the DUT for the read of register %0d", rd_idx);
            err_cnt++;
        end
        rdata = wb_dat_o[7:0];
    endtask

    task automatic reg_write(input logic [1:0] idx, input logic [7:0] data);
        logic [7:0] unused_rd;
        int         lag;
        bus_access(1'b1, idx, data, unused_rd, lag);
    endtask

    task automatic reg_check(input logic [1:0] idx, input logic [7:0] exp, input string what);
        logic [7:0] got;
        int         lag;
        bus_access(1'b0, idx, 8'h00, got, lag);
        if (got !== exp) begin
            $display("[ERROR] wb_dat_o (%s) got 0x%02h expected 0x%02h", what, got, exp);
            err_cnt++;
        end
    endtask

    // Address MSBs, LSBs, data, then read the byte back
    task automatic write_readback(input logic [10:0] a, input logic [7:0] data);
        reg_write(eth_regs_pkg::REG_TX_CNTL, {5'b00000, a[10:8]});
        reg_write(eth_regs_pkg::REG_TX_ADDR, a[7:0]);
        reg_write(eth_regs_pkg::REG_TX_DATA, data);
        reg_check(eth_regs_pkg::REG_TX_DATA, data, "buffer byte");
    endtask

    // ------------------------------
    // Frame send and line decode
    // ------------------------------
    task automatic send_frame(input logic [7:0] busy_stat, input logic [7:0] done_stat);
        logic [10:0] last;
        logic [7:0]  unused_rd;
        logic [7:0]  got;
        logic        first_half;
        logic        second_half;
        int          lag;
        last = 11'(frame_q.size() - 1);
        bus_access(1'b1, eth_regs_pkg::REG_TX_CNTL, {1'b1, 4'b0000, last[10:8]}, unused_rd, lag);
        fork
            begin
                repeat (5 - lag) @(negedge clk20);     // Edge E+4 carries byte 0, first half
                for (int k = 0; k < frame_q.size(); k++) begin
                    for (int j = 0; j < 8; j++) begin  // LSB first
                        first_half = Ethernet_tx_o;
                        @(negedge clk20);
                        second_half = Ethernet_tx_o;
                        @(negedge clk20);
                        if (first_half !== ~second_half) begin
                            $display("Manchester violation on Ethernet_tx_o in byte %0d bit %0d",
                                     k, j);
                            err_cnt++;
                        end
                        got[j] = second_half;
                    end
                    if (got !== frame_q[k]) begin
                        $display("[ERROR] Ethernet_tx_o byte %0d got 0x%02h expected 0x%02h",
                                 k, got, frame_q[k]);
                        err_cnt++;
                    end
                end
                for (int t = 0; t < TAIL; t++) begin
                    if (Ethernet_tx_o !== 1'b1) begin
                        $display("Line went low %0d cycles into the idle tail", t);
                        err_cnt++;
                    end
                    @(negedge clk20);
                end
                if (Ethernet_tx_o !== 1'b0) begin
                    $display("Line still high after the idle tail");
                    err_cnt++;
                end
            end
            begin
                repeat (3) @(negedge clk20);           // Busy is up by now
                reg_check(eth_regs_pkg::REG_TX_STAT, busy_stat, "status while sending");
            end
        join
        reg_check(eth_regs_pkg::REG_TX_STAT, done_stat, "status after frame");
        reg_check(eth_regs_pkg::REG_TX_CNTL, {5'b00000, last[10:8]}, "control after frame");
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        int          p;
        int          n;
        int          given;
        int          frame_no;
        int          wait_cyc;
        logic [15:0] flags;
        logic [7:0]  stat_rd;
        clk20     = 1'b0;
        wb_rst_i  = 1'b1;
        wb_dat_i  = 16'h0000;
        wb_cyc_i  = 1'b0;
        wb_stb_i  = 1'b0;
        wb_adr_i  = 1'b0;
        wb_sel_i  = 2'b00;
        wb_we_i   = 1'b0;
        err_cnt   = 0;
        test_cnt  = 0;
        test_fail = 0;
        test_err0 = 0;
        rng_state = 32'd70879;
        $readmemh("wb_ethernet_tx_stim.txt", stim_mem);

        // Sum of frame lengths sets the cycle budget
        cycle_limit = 4 * (1 << LP_W);
        p = 0;
        while (p < STIM_LEN - 3 && stim_mem[p] != 16'h0000) begin
            cycle_limit = cycle_limit + int'(stim_mem[p]) * 16 + 200;
            p = p + 3 + int'(stim_mem[p + 2]);
        end

        repeat (4) @(negedge clk20);
        wb_rst_i = 1'b0;

        reg_check(eth_regs_pkg::REG_TX_STAT, 8'h80, "status after reset");
        finish_test("reset_status");

        for (int i = 0; i < 3; i++) begin
            rng_state = next_random(rng_state);
            write_readback({1'b1, rng_state[9:0]}, rng_state[23:16]);
        end
        finish_test("high_address");

        p = 0;
        frame_no = 0;
        while (p < STIM_LEN - 3 && stim_mem[p] != 16'h0000) begin
            n     = int'(stim_mem[p]);
            flags = stim_mem[p + 1];
            given = int'(stim_mem[p + 2]);
            frame_q.delete();
            for (int i = 0; i < n; i++) begin
                if (i < given) begin
                    frame_q.push_back(stim_mem[p + 3 + i][7:0]);
                end else begin
                    rng_state = next_random(rng_state);    // Filler byte
                    frame_q.push_back(rng_state[7:0]);
                end
            end
            p = p + 3 + given;
            for (int i = 0; i < n; i++) begin
                write_readback(11'(i), frame_q[i]);
            end
            finish_test($sformatf("frame%0d_load", frame_no));
            send_frame(flags[15:8], flags[7:0]);
            finish_test($sformatf("frame%0d_line", frame_no));
            frame_no++;
        end

        // Clears the sent flag, the read on the next cycle still sees it clear
        write_then_read(eth_regs_pkg::REG_TX_STAT, 8'h00, eth_regs_pkg::REG_TX_STAT, stat_rd);
        if (stat_rd !== 8'h00) begin
            $display("[ERROR] wb_dat_o (status right after clear) got 0x%02h expected 0x%02h",
                     stat_rd, 8'h00);
            err_cnt++;
        end
        reg_check(eth_regs_pkg::REG_TX_STAT, 8'h80, "status after clear");
        finish_test("status_clear");

        wait_cyc = 0;
        while (Ethernet_tx_o !== 1'b1 && wait_cyc < (1 << LP_W) + 4) begin
            @(negedge clk20);
            wait_cyc++;
        end
        if (Ethernet_tx_o !== 1'b1) begin
            $display("No link pulse on Ethernet_tx_o within %0d cycles", wait_cyc);
            err_cnt++;
        end else begin
            @(negedge clk20);
            if (Ethernet_tx_o !== 1'b1) begin
                $display("Link pulse shorter than two cycles");
                err_cnt++;
            end
            @(negedge clk20);
            if (Ethernet_tx_o !== 1'b0) begin
                $display("Link pulse longer than two cycles");
                err_cnt++;
            end
        end
        finish_test("link_pulse");

        $display("tests %0d, failing tests %0d, errors %0d", test_cnt, test_fail, err_cnt);
        if (err_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- wb_ethernet_tx_stim.txt
// Per frame: length N (0 ends the list), status while sending and after (hi, lo byte),
// count K of given bytes, then K bytes; xorshift filler completes the frame
0004
4080
0004
55
d5
01
fe
000c
4080
0006
ff
ff
ff
ff
ff
ff
0001
4080
0001
a5
0018
4080
0000
0000

//--- wb_ethernet_tx.f
eth_regs_pkg.sv
tenbaset_pkg.sv
eth_tx_regs.sv
eth_tx_buffer.sv
tenbaset_txd.sv
wb_ethernet_tx.sv
tb_wb_ethernet_tx.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then look for the pass line in the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_wb_ethernet_tx \
    -f wb_ethernet_tx.f \
    -o tb_wb_ethernet_tx
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_wb_ethernet_tx > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "sim passed" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1
